/* design/mmu_pkg.sv */
package mmu_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int unsigned XLEN  = 64;
    localparam int unsigned VLEN  = 39;
    localparam int unsigned PLEN  = 56;
    localparam int unsigned PPNW  = 44;
    localparam int unsigned VPNW  = 27;
    localparam int unsigned OFFW  = 12;
    // asid field in the shared types, the top uses its low bits
    localparam int unsigned ASIDW = 16;

    typedef enum logic [1:0] {
        PAGE_4K,
        PAGE_2M,
        PAGE_1G
    } page_size_e;

    typedef enum logic [5:0] {
        CAUSE_INSTR_ACCESS = 6'd1,
        CAUSE_INSTR_PAGE   = 6'd12,
        CAUSE_LOAD_PAGE    = 6'd13,
        CAUSE_STORE_PAGE   = 6'd15
    } exc_cause_e;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_e;

    typedef struct packed {
        logic            valid;
        exc_cause_e      cause;
        logic [XLEN-1:0] tval;
    } exception_t;

    // leaf pte, permission and page fields only
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        logic            d;
        logic            a;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // --------------------------------------------------
    // refill path
    // --------------------------------------------------
    typedef struct packed {
        logic       valid;
        pte_t       pte;
        page_size_e size;
    } refill_t;

    typedef struct packed {
        logic             valid;
        logic [VPNW-1:0]  vpn;
        logic [ASIDW-1:0] asid;
        pte_t             pte;
        page_size_e       size;
    } tlb_update_t;

    typedef struct packed {
        logic             valid;
        logic [VPNW-1:0]  vpn;
        logic [ASIDW-1:0] asid;
    } refill_req_t;

    // --------------------------------------------------
    // request and response types
    // --------------------------------------------------
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] vaddr;
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        logic [PLEN-1:0] paddr;
        exception_t      ex;
    } fetch_rsp_t;

    typedef struct packed {
        logic            req;
        logic [VLEN-1:0] vaddr;
        logic            is_store;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        logic [PLEN-1:0] paddr;
        exception_t      ex;
    } lsu_rsp_t;

    typedef struct packed {
        logic             fetch_en;
        logic             lsu_en;
        priv_e            fetch_priv;
        priv_e            lsu_priv;
        logic             sum;
        logic [ASIDW-1:0] asid;
    } mmu_ctrl_t;

    // superpages take the low vpn levels straight from the virtual address
    function automatic logic [PLEN-1:0] compose_paddr(
        input logic [PPNW-1:0] ppn,
        input page_size_e      size,
        input logic [VLEN-1:0] vaddr
    );
        logic [PLEN-1:0] paddr;
        paddr = {ppn, vaddr[OFFW-1:0]};
        if (size == PAGE_2M) begin
            paddr[20:12] = vaddr[20:12];
        end
        if (size == PAGE_1G) begin
            paddr[29:12] = vaddr[29:12];
        end
        return paddr;
    endfunction

endpackage

/* design/tlb.sv */
`timescale 1ns/1ps

module tlb #(
    parameter int unsigned ENTRIES    = 4,
    parameter int unsigned ASID_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     flush_asid_i,
    input  logic [ASID_WIDTH-1:0]    flush_asid_val_i,
    input  mmu_pkg::tlb_update_t     update_i,
    input  logic [mmu_pkg::VLEN-1:0] lu_vaddr_i,
    input  logic [ASID_WIDTH-1:0]    lu_asid_i,
    output logic                     lu_hit_o,
    output mmu_pkg::pte_t            lu_pte_o,
    output mmu_pkg::page_size_e      lu_size_o
);
    import mmu_pkg::*;

    localparam int unsigned IDXW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    typedef struct packed {
        logic [VPNW-1:0]       vpn;
        logic [ASID_WIDTH-1:0] asid;
        page_size_e            size;
        pte_t                  pte;
    } entry_t;

    entry_t             entry_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] match;
    logic [IDXW-1:0]    victim_q;
    logic [VPNW-1:0]    lu_vpn;

    assign lu_vpn = lu_vaddr_i[VLEN-1:OFFW];

    // --------------------------------------------------
    // lookup
    // --------------------------------------------------
    // 1G compares vpn[2] only, 2M adds vpn[1], 4K needs all three
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (entry_q[i].asid == lu_asid_i)
                && (entry_q[i].vpn[26:18] == lu_vpn[26:18])
                && ((entry_q[i].size == PAGE_1G) || (entry_q[i].vpn[17:9] == lu_vpn[17:9]))
                && ((entry_q[i].size != PAGE_4K) || (entry_q[i].vpn[8:0] == lu_vpn[8:0]));
        end
    end

    always_comb begin
        lu_hit_o  = |match;
        lu_pte_o  = '0;
        lu_size_o = PAGE_4K;
        for (int i = 0; i < ENTRIES; i++) begin
            if (match[i]) begin
                lu_pte_o  = entry_q[i].pte;
                lu_size_o = entry_q[i].size;
            end
        end
    end

    // --------------------------------------------------
    // refill and flush
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            entry_q[victim_q].vpn  <= update_i.vpn;
            entry_q[victim_q].asid <= update_i.asid[ASID_WIDTH-1:0];
            entry_q[victim_q].size <= update_i.size;
            entry_q[victim_q].pte  <= update_i.pte;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else begin
            if (update_i.valid) begin
                valid_q[victim_q] <= 1'b1;
                victim_q <= (victim_q == IDXW'(ENTRIES - 1)) ? '0 : victim_q + 1'b1;
            end
            // a flush in the same cycle overrides the refill
            if (flush_i) begin
                valid_q <= '0;
            end else if (flush_asid_i) begin
                for (int i = 0; i < ENTRIES; i++) begin
                    if (entry_q[i].asid == flush_asid_val_i) begin
                        valid_q[i] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* design/fetch_translate.sv */
`timescale 1ns/1ps

module fetch_translate #(
    parameter int unsigned ENTRIES    = 4,
    parameter int unsigned ASID_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     flush_asid_i,
    input  logic [ASID_WIDTH-1:0]    flush_asid_val_i,
    input  mmu_pkg::tlb_update_t     update_i,
    input  mmu_pkg::fetch_req_t      req_i,
    input  mmu_pkg::mmu_ctrl_t       ctrl_i,
    output mmu_pkg::fetch_rsp_t      rsp_o,
    output logic                     miss_o,
    output logic [mmu_pkg::VPNW-1:0] miss_vpn_o
);
    import mmu_pkg::*;

    logic       hit;
    pte_t       pte;
    page_size_e size;
    logic       canonical;
    logic       priv_err;

    tlb #(
        .ENTRIES    (ENTRIES),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_itlb (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_asid_i     (flush_asid_i),
        .flush_asid_val_i (flush_asid_val_i),
        .update_i         (update_i),
        .lu_vaddr_i       (req_i.vaddr[VLEN-1:0]),
        .lu_asid_i        (ctrl_i.asid[ASID_WIDTH-1:0]),
        .lu_hit_o         (hit),
        .lu_pte_o         (pte),
        .lu_size_o        (size)
    );

    // upper bits must all copy bit 38
    assign canonical = (&req_i.vaddr[XLEN-1:VLEN-1]) || !(|req_i.vaddr[XLEN-1:VLEN-1]);
    assign priv_err  = ((ctrl_i.fetch_priv == PRIV_U) && !pte.u)
                    || ((ctrl_i.fetch_priv == PRIV_S) && pte.u);
    assign miss_vpn_o = req_i.vaddr[VLEN-1:OFFW];

    always_comb begin
        rsp_o.valid = req_i.req;
        rsp_o.paddr = req_i.vaddr[PLEN-1:0];
        rsp_o.ex    = '0;
        miss_o      = 1'b0;
        if (ctrl_i.fetch_en) begin
            rsp_o.paddr = compose_paddr(pte.ppn, size, req_i.vaddr[VLEN-1:0]);
            if (!canonical) begin
                rsp_o.ex = '{valid: req_i.req, cause: CAUSE_INSTR_ACCESS, tval: req_i.vaddr};
            end else if (hit) begin
                if (priv_err) begin
                    rsp_o.ex = '{valid: req_i.req, cause: CAUSE_INSTR_PAGE, tval: req_i.vaddr};
                end
            end else begin
                // hold off until the refill lands
                rsp_o.valid = 1'b0;
                miss_o      = req_i.req;
            end
        end
    end

endmodule

/* design/data_translate.sv */
`timescale 1ns/1ps

module data_translate #(
    parameter int unsigned ENTRIES    = 4,
    parameter int unsigned ASID_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     flush_asid_i,
    input  logic [ASID_WIDTH-1:0]    flush_asid_val_i,
    input  mmu_pkg::tlb_update_t     update_i,
    input  mmu_pkg::lsu_req_t        req_i,
    input  mmu_pkg::mmu_ctrl_t       ctrl_i,
    output mmu_pkg::lsu_rsp_t        rsp_o,
    output logic                     miss_o,
    output logic [mmu_pkg::VPNW-1:0] miss_vpn_o
);
    import mmu_pkg::*;

    // request, its privilege settings and lookup result carried into the response cycle
    typedef struct packed {
        logic [VLEN-1:0] vaddr;
        logic            is_store;
        logic            en;
        priv_e           priv;
        logic            sum;
        pte_t            pte;
        page_size_e      size;
    } stage_t;

    stage_t          stage_d;
    stage_t          stage_q;
    logic            req_q;
    logic            hit_q;
    logic            hit;
    pte_t            pte;
    page_size_e      size;
    logic            acc_err;
    logic [XLEN-1:0] tval;

    tlb #(
        .ENTRIES    (ENTRIES),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_dtlb (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_asid_i     (flush_asid_i),
        .flush_asid_val_i (flush_asid_val_i),
        .update_i         (update_i),
        .lu_vaddr_i       (req_i.vaddr),
        .lu_asid_i        (ctrl_i.asid[ASID_WIDTH-1:0]),
        .lu_hit_o         (hit),
        .lu_pte_o         (pte),
        .lu_size_o        (size)
    );

    assign miss_o     = req_i.req && ctrl_i.lsu_en && !hit;
    assign miss_vpn_o = req_i.vaddr[VLEN-1:OFFW];
    assign stage_d    = '{vaddr: req_i.vaddr, is_store: req_i.is_store, en: ctrl_i.lsu_en,
                          priv: ctrl_i.lsu_priv, sum: ctrl_i.sum, pte: pte, size: size};

    // --------------------------------------------------
    // stage register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= req_i.req;
            hit_q <= hit;
        end
    end

    always_ff @(posedge clk_i) begin
        stage_q <= stage_d;
    end

    // --------------------------------------------------
    // response and fault checks
    // --------------------------------------------------
    assign acc_err = ((stage_q.priv == PRIV_S) && !stage_q.sum && stage_q.pte.u)
                  || ((stage_q.priv == PRIV_U) && !stage_q.pte.u);
    assign tval    = {{(XLEN - VLEN){stage_q.vaddr[VLEN-1]}}, stage_q.vaddr};

    always_comb begin
        rsp_o.valid = req_q;
        rsp_o.paddr = PLEN'(stage_q.vaddr);
        rsp_o.ex    = '0;
        if (stage_q.en) begin
            rsp_o.valid = req_q && hit_q;
            rsp_o.paddr = compose_paddr(stage_q.pte.ppn, stage_q.size, stage_q.vaddr);
            if (req_q && hit_q) begin
                if (stage_q.is_store) begin
                    // stores also need a writable, already dirty page
                    if (acc_err || !stage_q.pte.w || !stage_q.pte.d) begin
                        rsp_o.ex = '{valid: 1'b1, cause: CAUSE_STORE_PAGE, tval: tval};
                    end
                end else if (acc_err) begin
                    rsp_o.ex = '{valid: 1'b1, cause: CAUSE_LOAD_PAGE, tval: tval};
                end
            end
        end
    end

endmodule

/* design/miss_arbiter.sv */
`timescale 1ns/1ps

module miss_arbiter #(
    parameter int unsigned ASID_WIDTH = 4
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     i_miss_i,
    input  logic [mmu_pkg::VPNW-1:0] i_vpn_i,
    input  logic                     d_miss_i,
    input  logic [mmu_pkg::VPNW-1:0] d_vpn_i,
    input  logic [ASID_WIDTH-1:0]    asid_i,
    input  mmu_pkg::refill_t         refill_i,
    output mmu_pkg::refill_req_t     refill_req_o,
    output mmu_pkg::tlb_update_t     itlb_update_o,
    output mmu_pkg::tlb_update_t     dtlb_update_o
);
    import mmu_pkg::*;

    logic                  pending_q;
    logic                  req_q;
    // set when the data TLB is being refilled
    logic                  target_q;
    logic [VPNW-1:0]       vpn_q;
    logic [ASID_WIDTH-1:0] asid_q;
    logic                  accept;
    tlb_update_t           update;

    // fetch wins a tie, misses while pending are dropped
    assign accept = !pending_q && (i_miss_i || d_miss_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
            req_q     <= 1'b0;
            target_q  <= 1'b0;
        end else begin
            req_q <= accept;
            if (accept) begin
                pending_q <= 1'b1;
                target_q  <= !i_miss_i;
            end else if (refill_i.valid) begin
                pending_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            vpn_q  <= i_miss_i ? i_vpn_i : d_vpn_i;
            asid_q <= asid_i;
        end
    end

    assign refill_req_o = '{valid: req_q, vpn: vpn_q, asid: ASIDW'(asid_q)};

    // --------------------------------------------------
    // steer the returned leaf to the waiting TLB
    // --------------------------------------------------
    always_comb begin
        update = '{valid: refill_i.valid && pending_q, vpn: vpn_q, asid: ASIDW'(asid_q),
                   pte: refill_i.pte, size: refill_i.size};
        itlb_update_o = '0;
        dtlb_update_o = '0;
        if (target_q) begin
            dtlb_update_o = update;
        end else begin
            itlb_update_o = update;
        end
    end

endmodule

/* design/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top #(
    parameter int unsigned ITLB_ENTRIES = 4,
    parameter int unsigned DTLB_ENTRIES = 4,
    parameter int unsigned ASID_WIDTH   = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  mmu_pkg::fetch_req_t   fetch_req_i,
    input  mmu_pkg::lsu_req_t     lsu_req_i,
    input  mmu_pkg::mmu_ctrl_t    ctrl_i,
    input  mmu_pkg::refill_t      refill_i,
    input  logic                  flush_i,
    input  logic                  flush_asid_i,
    input  logic [ASID_WIDTH-1:0] flush_asid_val_i,
    output mmu_pkg::fetch_rsp_t   fetch_rsp_o,
    output mmu_pkg::lsu_rsp_t     lsu_rsp_o,
    output mmu_pkg::refill_req_t  refill_req_o
);
    import mmu_pkg::*;

    logic            i_miss;
    logic [VPNW-1:0] i_vpn;
    logic            d_miss;
    logic [VPNW-1:0] d_vpn;
    tlb_update_t     itlb_update;
    tlb_update_t     dtlb_update;

    // --------------------------------------------------
    // instruction side
    // --------------------------------------------------
    fetch_translate #(
        .ENTRIES    (ITLB_ENTRIES),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_fetch (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_asid_i     (flush_asid_i),
        .flush_asid_val_i (flush_asid_val_i),
        .update_i         (itlb_update),
        .req_i            (fetch_req_i),
        .ctrl_i           (ctrl_i),
        .rsp_o            (fetch_rsp_o),
        .miss_o           (i_miss),
        .miss_vpn_o       (i_vpn)
    );

    // --------------------------------------------------
    // load/store side
    // --------------------------------------------------
    data_translate #(
        .ENTRIES    (DTLB_ENTRIES),
        .ASID_WIDTH (ASID_WIDTH)
    ) i_data (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_asid_i     (flush_asid_i),
        .flush_asid_val_i (flush_asid_val_i),
        .update_i         (dtlb_update),
        .req_i            (lsu_req_i),
        .ctrl_i           (ctrl_i),
        .rsp_o            (lsu_rsp_o),
        .miss_o           (d_miss),
        .miss_vpn_o       (d_vpn)
    );

    miss_arbiter #(
        .ASID_WIDTH (ASID_WIDTH)
    ) i_arb (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .i_miss_i      (i_miss),
        .i_vpn_i       (i_vpn),
        .d_miss_i      (d_miss),
        .d_vpn_i       (d_vpn),
        .asid_i        (ctrl_i.asid[ASID_WIDTH-1:0]),
        .refill_i      (refill_i),
        .refill_req_o  (refill_req_o),
        .itlb_update_o (itlb_update),
        .dtlb_update_o (dtlb_update)
    );

endmodule

/* verif/mmu_properties.sv */
`timescale 1ns/1ps

module mmu_properties (
    input logic                 clk_i,
    input logic                 rst_ni,
    input mmu_pkg::refill_req_t refill_req_o,
    input mmu_pkg::refill_t     refill_i,
    input mmu_pkg::lsu_req_t    lsu_req_i,
    input mmu_pkg::lsu_rsp_t    lsu_rsp_o,
    input mmu_pkg::fetch_rsp_t  fetch_rsp_o
);
    import mmu_pkg::*;

    // outstanding refill as seen from the ports
    logic pend_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= 1'b0;
        end else if (refill_req_o.valid) begin
            pend_q <= 1'b1;
        end else if (refill_i.valid) begin
            pend_q <= 1'b0;
        end
    end

    single_refill_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        refill_req_o.valid |-> !pend_q)
        else $error("refill request raised while another is pending");

    lsu_valid_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_rsp_o.valid |-> $past(lsu_req_i.req))
        else $error("load/store response valid without a request");

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !lsu_rsp_o.valid && !fetch_rsp_o.valid && !refill_req_o.valid)
        else $error("outputs active right after reset");

endmodule

bind mmu_top mmu_properties props0 (.*);

/* verif/mmu_checker.sv */
`timescale 1ns/1ps

module mmu_checker (
    input  logic                 clk_i,
    input  logic                 active_i,
    input  logic                 lsu_i,
    input  logic [8*20-1:0]      name_i,
    input  logic [63:0]          vaddr_i,
    input  logic [15:0]          asid_i,
    input  logic [55:0]          exp_paddr_i,
    input  logic                 exp_ex_i,
    input  mmu_pkg::exc_cause_e  exp_cause_i,
    input  logic                 exp_refill_i,
    input  mmu_pkg::fetch_rsp_t  fetch_rsp_i,
    input  mmu_pkg::lsu_rsp_t    lsu_rsp_i,
    input  mmu_pkg::refill_req_t refill_req_i,
    output logic                 done_o,
    output int                   val_errs_o,
    output int                   req_errs_o
);
    import mmu_pkg::*;

    logic       seen;
    logic       valid;
    logic [55:0] paddr;
    exception_t ex;

    initial begin
        done_o     = 1'b0;
        seen       = 1'b0;
        val_errs_o = 0;
        req_errs_o = 0;
    end

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin
        valid = lsu_i ? lsu_rsp_i.valid : fetch_rsp_i.valid;
        paddr = lsu_i ? lsu_rsp_i.paddr : fetch_rsp_i.paddr;
        ex    = lsu_i ? lsu_rsp_i.ex : fetch_rsp_i.ex;
        if (!active_i) begin
            done_o = 1'b0;
            seen   = 1'b0;
        end else begin
            // refill requests stay watched past a response that came at once
            if (refill_req_i.valid) begin
                seen = 1'b1;
                if (!exp_refill_i) begin
                    $display("%0s: refill request where the TLB should hit", name_i);
                    req_errs_o++;
                end
                if (refill_req_i.vpn != vaddr_i[38:12]) begin
                    $display("ERR %0s vpn exp %h act %h", name_i, vaddr_i[38:12],
                             refill_req_i.vpn);
                    req_errs_o++;
                end
                if (refill_req_i.asid != asid_i) begin
                    $display("ERR %0s asid exp %h act %h", name_i, asid_i, refill_req_i.asid);
                    req_errs_o++;
                end
            end
            if (valid && !done_o) begin
                done_o = 1'b1;
                if (exp_refill_i && !seen) begin
                    $display("%0s: response came without the expected refill", name_i);
                    req_errs_o++;
                end
                if (ex.valid != exp_ex_i) begin
                    $display("ERR %0s ex.valid exp %b act %b", name_i, exp_ex_i, ex.valid);
                    val_errs_o++;
                end else if (exp_ex_i) begin
                    if (ex.cause != exp_cause_i) begin
                        $display("ERR %0s cause exp %0d act %0d", name_i, exp_cause_i, ex.cause);
                        val_errs_o++;
                    end
                    if (ex.tval != vaddr_i) begin
                        $display("ERR %0s tval exp %h act %h", name_i, vaddr_i, ex.tval);
                        val_errs_o++;
                    end
                end else if (paddr != exp_paddr_i) begin
                    $display("ERR %0s paddr exp %h act %h", name_i, exp_paddr_i, paddr);
                    val_errs_o++;
                end
            end
        end
    end

endmodule

/* verif/mmu_tb.sv */
`timescale 1ns/1ps

module mmu_tb;
    import mmu_pkg::*;

    typedef struct packed {
        logic [8*20-1:0] name;
        logic            lsu;
        logic            en;
        priv_e           priv;
        logic            sum;
        logic [15:0]     asid;
        logic [1:0]      flush;
        logic [3:0]      fasid;
        logic [63:0]     vaddr;
        logic            store;
        pte_t            pte;
        page_size_e      size;
        logic [55:0]     paddr;
        logic            ex;
        exc_cause_e      cause;
        logic            refill;
    } test_t;

    logic        clk_i;
    logic        rst_ni;
    fetch_req_t  fetch_req;
    lsu_req_t    lsu_req;
    mmu_ctrl_t   ctrl;
    refill_t     refill;
    logic        flush;
    logic        flush_asid;
    logic [3:0]  flush_asid_val;
    fetch_rsp_t  fetch_rsp;
    lsu_rsp_t    lsu_rsp;
    refill_req_t refill_req;
    test_t       tests[$];
    test_t       cur;
    logic        active;
    logic        done;
    int          val_errs;
    int          req_errs;
    int          seed = 56129;
    int          delay = 0;
    int          cycles = 0;
    int          limit = 1000;

    mmu_top #(.ITLB_ENTRIES(4), .DTLB_ENTRIES(4), .ASID_WIDTH(4)) dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .fetch_req_i(fetch_req), .lsu_req_i(lsu_req),
        .ctrl_i(ctrl), .refill_i(refill), .flush_i(flush), .flush_asid_i(flush_asid),
        .flush_asid_val_i(flush_asid_val), .fetch_rsp_o(fetch_rsp), .lsu_rsp_o(lsu_rsp),
        .refill_req_o(refill_req)
    );

    mmu_checker chk0 (
        .clk_i(clk_i), .active_i(active), .lsu_i(cur.lsu), .name_i(cur.name),
        .vaddr_i(cur.vaddr), .asid_i(cur.asid), .exp_paddr_i(cur.paddr), .exp_ex_i(cur.ex),
        .exp_cause_i(cur.cause), .exp_refill_i(cur.refill), .fetch_rsp_i(fetch_rsp),
        .lsu_rsp_i(lsu_rsp), .refill_req_i(refill_req), .done_o(done),
        .val_errs_o(val_errs), .req_errs_o(req_errs)
    );

    always #4 clk_i = ~clk_i;

    // page-table agent, answers after one to three cycles
    always @(posedge clk_i) begin
        refill <= '0;
        if (delay > 0) begin
            delay <= delay - 1;
            if (delay == 1) begin
                refill <= '{valid: 1'b1, pte: cur.pte, size: cur.size};
            end
        end else if (refill_req.valid) begin
            delay <= 1 + ({$random(seed)} % 3);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: test %0s did not finish within %0d cycles", cur.name, limit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic add_test(input logic [8*20-1:0] name, input logic lsu, input logic en,
                            input priv_e priv, input logic sum, input logic [15:0] asid,
                            input logic [1:0] flush, input logic [3:0] fasid,
                            input logic [63:0] vaddr, input logic store,
                            input logic [43:0] ppn, input logic [6:0] flags,
                            input page_size_e size, input logic [55:0] paddr,
                            input logic ex, input exc_cause_e cause, input logic refill);
        test_t t;
        t = '{name, lsu, en, priv, sum, asid, flush, fasid, vaddr, store,
              {ppn, flags}, size, paddr, ex, cause, refill};
        tests.push_back(t);
    endtask

    // --------------------------------------------------
    // stimulus table
    // --------------------------------------------------
    // flags are d a u x w r v, flush 1 is full and 2 is by asid
    task automatic build_table();
        add_test("off_fetch", 0, 0, PRIV_S, 0, 1, 0, 0, 64'h12_3456_7abc, 0,
                 0, 7'h00, PAGE_4K, 56'h12_3456_7abc, 0, CAUSE_INSTR_ACCESS, 0);
        add_test("off_load", 1, 0, PRIV_S, 0, 1, 0, 0, 64'h1_2345_6788, 0,
                 0, 7'h00, PAGE_4K, 56'h1_2345_6788, 0, CAUSE_INSTR_ACCESS, 0);
        add_test("miss_4k_fetch", 0, 1, PRIV_S, 0, 1, 0, 0, 64'h8000_1234, 0,
                 44'h80042, 7'b1101011, PAGE_4K, 56'h8004_2234, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("hit_4k_fetch", 0, 1, PRIV_S, 0, 1, 0, 0, 64'h8000_1567, 0,
                 44'h80042, 7'b1101011, PAGE_4K, 56'h8004_2567, 0, CAUSE_INSTR_ACCESS, 0);
        add_test("miss_2m_load", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h4012_3456, 0,
                 44'hc00, 7'b1100111, PAGE_2M, 56'hd2_3456, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("miss_1g_load", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h8765_4321, 0,
                 44'h40000, 7'b1100111, PAGE_1G, 56'h4765_4321, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("ld_upage_nosum", 1, 1, PRIV_S, 0, 1, 0, 0, 64'hffff_ffff_ffff_f008, 0,
                 44'h123, 7'b1110111, PAGE_4K, 56'h0, 1, CAUSE_LOAD_PAGE, 1);
        add_test("ld_upage_sum", 1, 1, PRIV_S, 1, 1, 0, 0, 64'hffff_ffff_ffff_f008, 0,
                 44'h123, 7'b1110111, PAGE_4K, 56'h12_3008, 0, CAUSE_INSTR_ACCESS, 0);
        add_test("ld_user_spage", 1, 1, PRIV_U, 0, 1, 0, 0, 64'h4012_3456, 0,
                 44'hc00, 7'b1100111, PAGE_2M, 56'h0, 1, CAUSE_LOAD_PAGE, 0);
        add_test("st_no_w", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h50_2000, 1,
                 44'h222, 7'b1100011, PAGE_4K, 56'h0, 1, CAUSE_STORE_PAGE, 1);
        add_test("st_no_d", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h50_3000, 1,
                 44'h223, 7'b0100111, PAGE_4K, 56'h0, 1, CAUSE_STORE_PAGE, 1);
        add_test("st_ok", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h50_4010, 1,
                 44'h224, 7'b1100111, PAGE_4K, 56'h22_4010, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("fetch_noncanon", 0, 1, PRIV_S, 0, 1, 0, 0, 64'h1_0000_0000_0000, 0,
                 0, 7'h00, PAGE_4K, 56'h0, 1, CAUSE_INSTR_ACCESS, 0);
        add_test("fetch_user_spage", 0, 1, PRIV_U, 0, 1, 0, 0, 64'h8000_1100, 0,
                 44'h80042, 7'b1101011, PAGE_4K, 56'h0, 1, CAUSE_INSTR_PAGE, 0);
        add_test("asid2_fetch_miss", 0, 1, PRIV_S, 0, 2, 0, 0, 64'h60_0000, 0,
                 44'h300, 7'b1101011, PAGE_4K, 56'h30_0000, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("flush_asid1_keep2", 0, 1, PRIV_S, 0, 2, 2, 1, 64'h60_0040, 0,
                 44'h300, 7'b1101011, PAGE_4K, 56'h30_0040, 0, CAUSE_INSTR_ACCESS, 0);
        add_test("flush_asid1_miss", 0, 1, PRIV_S, 0, 1, 0, 0, 64'h8000_1234, 0,
                 44'h80042, 7'b1101011, PAGE_4K, 56'h8004_2234, 0, CAUSE_INSTR_ACCESS, 1);
        // reloads the data TLB so the full flush below has a live entry to remove
        add_test("flush_asid1_ld_miss", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h50_4010, 0,
                 44'h224, 7'b1100111, PAGE_4K, 56'h22_4010, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("flush_all_fetch", 0, 1, PRIV_S, 0, 2, 1, 0, 64'h60_0080, 0,
                 44'h300, 7'b1101011, PAGE_4K, 56'h30_0080, 0, CAUSE_INSTR_ACCESS, 1);
        add_test("flush_all_load", 1, 1, PRIV_S, 0, 1, 0, 0, 64'h50_4010, 0,
                 44'h224, 7'b1100111, PAGE_4K, 56'h22_4010, 0, CAUSE_INSTR_ACCESS, 1);
    endtask

    initial begin
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        fetch_req      = '0;
        lsu_req        = '0;
        ctrl           = '0;
        refill         = '0;
        flush          = 1'b0;
        flush_asid     = 1'b0;
        flush_asid_val = '0;
        active         = 1'b0;
        cur            = '0;
        build_table();
        limit = 20 * tests.size() + 50;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (tests[i]) begin
            @(posedge clk_i);
            cur  <= tests[i];
            ctrl <= '{fetch_en: tests[i].en, lsu_en: tests[i].en, fetch_priv: tests[i].priv,
                      lsu_priv: tests[i].priv, sum: tests[i].sum, asid: tests[i].asid};
            if (tests[i].flush != 2'd0) begin
                flush          <= (tests[i].flush == 2'd1);
                flush_asid     <= (tests[i].flush == 2'd2);
                flush_asid_val <= tests[i].fasid;
                @(posedge clk_i);
                flush      <= 1'b0;
                flush_asid <= 1'b0;
            end
            if (tests[i].lsu) begin
                lsu_req <= '{req: 1'b1, vaddr: tests[i].vaddr[38:0], is_store: tests[i].store};
            end else begin
                fetch_req <= '{req: 1'b1, vaddr: tests[i].vaddr};
            end
            active <= 1'b1;
            @(posedge clk_i);
            while (!done) @(posedge clk_i);
            fetch_req <= '0;
            lsu_req   <= '0;
            // one more cycle so a late refill request is still seen
            @(posedge clk_i);
            active    <= 1'b0;
        end
        @(posedge clk_i);
        $display("errors: value %0d refill %0d", val_errs, req_errs);
        if (val_errs == 0 && req_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
design/mmu_pkg.sv
design/tlb.sv
design/fetch_translate.sv
design/data_translate.sv
design/miss_arbiter.sv
design/mmu_top.sv
verif/mmu_properties.sv
verif/mmu_checker.sv
verif/mmu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module mmu_tb --Mdir obj_dir -o mmu_tb_sim

run: compile
	./obj_dir/mmu_tb_sim | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
